//--- common/csi2_pkg.sv
`default_nettype none

package csi2_pkg;

    // short packet data types
    localparam logic [7:0] dt_frame_start = 8'h00;
    localparam logic [7:0] dt_frame_end   = 8'h01;

    localparam logic [15:0] crc_seed = 16'hffff;

    // header field, word count or frame number
    typedef union packed {
        logic [15:0] word_count;
        logic [15:0] frame_number;
    } ph_field_u;

    // wire order, data_id in the low byte
    typedef struct packed {
        logic [7:0] ecc;
        ph_field_u  field;
        logic [7:0] data_id;
    } ph_t;

    // ecc column per header bit, bit 23 first
    localparam logic [23:0][5:0] ecc_code = {
        6'h3b, 6'h37, 6'h2f, 6'h1f,
        6'h38, 6'h34, 6'h32, 6'h31,
        6'h2c, 6'h2a, 6'h29, 6'h26,
        6'h25, 6'h23, 6'h1c, 6'h1a,
        6'h19, 6'h16, 6'h15, 6'h13,
        6'h0e, 6'h0d, 6'h0b, 6'h07
    };

    function automatic logic [5:0] ecc_syndrome(input logic [23:0] header);
        logic [5:0] syn;
        syn = '0;
        for (int i = 0; i < 24; i++) begin
            if (header[i]) begin
                syn = syn ^ ecc_code[i];
            end
        end
        return syn;
    endfunction

    // reflected crc-16, low byte first, lsb first
    function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [15:0] data);
        logic [15:0] c;
        c = crc;
        for (int i = 0; i < 16; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ 16'h8408;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

//--- common/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // one 16-bit beat, two bytes
    typedef struct packed {
        logic        valid;
        logic        user;
        logic        last;
        logic [15:0] data;
    } beat_t;

    // one-cycle event strobes
    typedef struct packed {
        logic frame_start;
        logic frame_end;
        logic ecc_valid;
        logic ecc_corrected;
        logic ecc_error;
        logic crc_valid;
        logic crc_error;
        logic packet_lost;
    } rx_status_t;

endpackage

`default_nettype wire

//--- csi2_rx.f
common/csi2_pkg.sv
common/stream_pkg.sv
csi2_rx/csi2_ecc24.sv
csi2_rx/csi2_rx_packet.sv
verilog/stream_fifo.sv
verilog/csi2_rx_top.sv
dv/csi2_rx_checker.sv
dv/csi2_rx_tb.sv

//--- csi2_rx/csi2_ecc24.sv
`default_nettype none

module csi2_ecc24 (
    input  var logic        s_axi4s,
    input  var logic        rst,
    input  var logic        cke,
    input  var logic [23:0] s_header,
    input  var logic [5:0]  s_ecc,
    input  var logic [17:0] s_side,
    input  var logic        s_valid,
    output logic     [23:0] m_header,
    output logic     [17:0] m_side,
    output logic            m_valid,
    output logic            m_error,
    output logic            m_corrected
);

    logic [5:0]  syndrome;
    logic [23:0] flip;
    logic        hdr_bit;
    logic        ecc_bit;

    assign syndrome = csi2_pkg::ecc_syndrome(s_header) ^ s_ecc;

    // locate the header bit named by the syndrome
    always_comb begin
        flip = '0;
        for (int i = 0; i < 24; i++) begin
            if (syndrome == csi2_pkg::ecc_code[i]) begin
                flip[i] = 1'b1;
            end
        end
    end

    assign hdr_bit = |flip;

    // single set bit means the ecc byte itself took the hit
    assign ecc_bit = (syndrome != 6'd0) && ((syndrome & (syndrome - 6'd1)) == 6'd0);

    always_ff @(posedge s_axi4s) begin
        if (rst) begin
            m_valid     <= 1'b0;
            m_error     <= 1'b0;
            m_corrected <= 1'b0;
        end else if (cke) begin
            m_valid     <= s_valid;
            m_corrected <= hdr_bit || ecc_bit;
            m_error     <= (syndrome != 6'd0) && !hdr_bit && !ecc_bit;
        end
    end

    always_ff @(posedge s_axi4s) begin
        if (cke) begin
            m_header <= s_header ^ flip;
            m_side   <= s_side;
        end
    end

endmodule

`default_nettype wire

//--- csi2_rx/csi2_rx_packet.sv
`default_nettype none

module csi2_rx_packet (
    input  var logic                   s_axi4s,
    input  var logic                   rst,
    input  var logic [7:0]             data_type,
    input  var stream_pkg::beat_t      s_beat,
    output logic                       s_ready,
    output stream_pkg::beat_t          m_beat,
    input  var logic                   m_ready,
    output stream_pkg::rx_status_t     status
);

    logic advance;

    // whole pipeline moves together
    assign advance = !m_beat.valid || m_ready;
    assign s_ready = advance;

    // ------------------------------
    // stage 0, header capture
    // ------------------------------
    csi2_pkg::ph_t st0_header;
    logic          st0_wait;
    logic          st0_ph;
    logic          st0_last;
    logic [15:0]   st0_data;
    logic          st0_valid;

    always_ff @(posedge s_axi4s) begin
        if (rst) begin
            st0_wait  <= 1'b0;
            st0_ph    <= 1'b0;
            st0_valid <= 1'b0;
        end else if (advance) begin
            st0_valid <= s_beat.valid;
            st0_ph    <= s_beat.valid && !s_beat.user && st0_wait;
            if (s_beat.valid) begin
                st0_wait <= s_beat.user;
            end
        end
    end

    always_ff @(posedge s_axi4s) begin
        if (advance) begin
            st0_last <= s_beat.last;
            st0_data <= s_beat.data;
            if (s_beat.valid && s_beat.user) begin
                st0_header.data_id               <= s_beat.data[7:0];
                st0_header.field.word_count[7:0] <= s_beat.data[15:8];
            end else if (s_beat.valid && st0_wait) begin
                st0_header.field.word_count[15:8] <= s_beat.data[7:0];
                st0_header.ecc                    <= s_beat.data[15:8];
            end
        end
    end

    // ------------------------------
    // ecc stage
    // ------------------------------
    logic [23:0]         ecc_header;
    csi2_pkg::ph_field_u ecc_field;
    logic [7:0]          ecc_id;
    logic                ecc_ph;
    logic                ecc_last;
    logic [15:0]         ecc_data;
    logic                ecc_valid;
    logic                ecc_error;
    logic                ecc_corrected;
    logic                ecc_hdr;

    csi2_ecc24 u_ecc24 (
        .s_axi4s     (s_axi4s),
        .rst         (rst),
        .cke         (advance),
        .s_header    ({st0_header.field, st0_header.data_id}),
        .s_ecc       (st0_header.ecc[5:0]),
        .s_side      ({st0_ph, st0_last, st0_data}),
        .s_valid     (st0_valid),
        .m_header    (ecc_header),
        .m_side      ({ecc_ph, ecc_last, ecc_data}),
        .m_valid     (ecc_valid),
        .m_error     (ecc_error),
        .m_corrected (ecc_corrected)
    );

    assign {ecc_field, ecc_id} = ecc_header;
    assign ecc_hdr = ecc_valid && ecc_ph;

    // ------------------------------
    // stage 1, packet fsm
    // ------------------------------
    typedef enum logic [1:0] {
        st1_idle = 2'd0,
        st1_data = 2'd1,
        st1_crc  = 2'd2
    } st1_state_t;

    st1_state_t  st1_state;
    logic        st1_match;
    logic        st1_sof;
    logic [15:0] st1_count;
    logic [15:0] st1_crc_sum;
    logic        st1_fs;
    logic        st1_fe;
    logic        st1_crc_valid;
    logic        st1_crc_error;
    logic        st1_lost;
    logic        is_fs;
    logic        payload_end;

    assign is_fs       = ecc_id[5:0] == csi2_pkg::dt_frame_start[5:0];
    assign payload_end = st1_count <= 16'd2;

    always_ff @(posedge s_axi4s) begin
        if (rst) begin
            st1_state     <= st1_idle;
            st1_match     <= 1'b0;
            st1_sof       <= 1'b0;
            m_beat.valid  <= 1'b0;
            st1_fs        <= 1'b0;
            st1_fe        <= 1'b0;
            st1_crc_valid <= 1'b0;
            st1_crc_error <= 1'b0;
            st1_lost      <= 1'b0;
        end else if (advance) begin
            m_beat.valid  <= 1'b0;
            m_beat.user   <= 1'b0;
            m_beat.last   <= 1'b0;
            m_beat.data   <= ecc_data;
            st1_fs        <= 1'b0;
            st1_fe        <= 1'b0;
            st1_crc_valid <= 1'b0;
            st1_crc_error <= 1'b0;
            st1_lost      <= 1'b0;

            if (ecc_hdr) begin
                if (ecc_error) begin
                    // uncorrectable header, drop
                    st1_state <= st1_idle;
                    st1_match <= 1'b0;
                end else if (ecc_id[5:4] == 2'b00) begin
                    st1_state <= st1_idle;
                    st1_match <= 1'b0;
                    st1_fs    <= is_fs;
                    st1_fe    <= ecc_id[5:0] == csi2_pkg::dt_frame_end[5:0];
                    st1_sof   <= st1_sof || is_fs;
                end else if (ecc_last) begin
                    // long header with nothing behind it
                    st1_state <= st1_idle;
                    st1_match <= 1'b0;
                    st1_lost  <= 1'b1;
                end else begin
                    st1_state   <= (ecc_field.word_count == 16'd0) ? st1_crc : st1_data;
                    st1_match   <= ecc_id == data_type;
                    st1_count   <= ecc_field.word_count;
                    st1_crc_sum <= csi2_pkg::crc_seed;
                end
            end else if (ecc_valid) begin
                case (st1_state)
                    st1_data: begin
                        m_beat.valid <= st1_match;
                        m_beat.user  <= st1_sof;
                        // an aborted payload still closes with last
                        m_beat.last  <= payload_end || ecc_last;
                        st1_crc_sum  <= csi2_pkg::crc16_step(st1_crc_sum, ecc_data);
                        st1_count    <= st1_count - 16'd2;
                        if (st1_match) begin
                            st1_sof <= 1'b0;
                        end
                        if (ecc_last) begin
                            st1_state <= st1_idle;
                            st1_match <= 1'b0;
                            st1_lost  <= 1'b1;
                        end else if (payload_end) begin
                            st1_state <= st1_crc;
                        end
                    end
                    st1_crc: begin
                        st1_state     <= st1_idle;
                        st1_match     <= 1'b0;
                        st1_crc_valid <= st1_match;
                        st1_crc_error <= st1_match && (ecc_data != st1_crc_sum);
                    end
                    default: begin
                        st1_state <= st1_idle;
                    end
                endcase
            end
        end
    end

    // strobes show once, on the advancing cycle
    always_comb begin
        status.frame_start   = st1_fs && advance;
        status.frame_end     = st1_fe && advance;
        status.ecc_valid     = ecc_hdr && advance;
        status.ecc_corrected = ecc_hdr && ecc_corrected && advance;
        status.ecc_error     = ecc_hdr && ecc_error && advance;
        status.crc_valid     = st1_crc_valid && advance;
        status.crc_error     = st1_crc_error && advance;
        status.packet_lost   = st1_lost && advance;
    end

endmodule

`default_nettype wire

//--- dv/csi2_rx_checker.sv
`default_nettype none

module csi2_rx_checker (
    input var logic                   s_axi4s,
    input var logic                   rst,
    input var stream_pkg::beat_t      m_beat,
    input var logic                   m_ready,
    input var stream_pkg::rx_status_t status
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    ecc_exclusive: assert property (@(posedge s_axi4s) disable iff (rst)
        !(status.ecc_error && status.ecc_corrected))
        else begin
            $error("ecc_error and ecc_corrected high in the same cycle");
            fail_count++;
        end

    // output held while stalled
    output_hold: assert property (@(posedge s_axi4s) disable iff (rst)
        (m_beat.valid && !m_ready) |=> $stable(m_beat))
        else begin
            $error("m_beat changed while valid and not ready");
            fail_count++;
        end

    crc_error_valid: assert property (@(posedge s_axi4s) disable iff (rst)
        status.crc_error |-> status.crc_valid)
        else begin
            $error("crc_error without crc_valid");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge s_axi4s)
        rst |=> (!rst || status == '0))
        else begin
            $error("status strobe high during reset");
            fail_count++;
        end

endmodule

bind csi2_rx_top csi2_rx_checker u_checker (
    .s_axi4s (s_axi4s),
    .rst     (rst),
    .m_beat  (m_beat),
    .m_ready (m_ready),
    .status  (status)
);

`default_nettype wire

//--- dv/csi2_rx_tb.sv
`default_nettype none

module csi2_rx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          fifo_depth = 16;
    localparam logic [7:0]  rx_type    = 8'h2b;
    localparam logic [7:0]  other_type = 8'h2a;
    localparam logic [31:0] seed_init  = 32'h0765e5b0;

    // 61 directed beats plus the stall test
    localparam int rand_packets = 16;
    localparam int rand_wc      = 24;
    localparam int stim_beats   = 61 + 4 + rand_packets * (3 + rand_wc / 2);
    localparam int cycle_limit  = 2 * stim_beats + 200;

    logic                   s_axi4s;
    logic                   rst;
    logic [7:0]             data_type;
    stream_pkg::beat_t      s_beat;
    logic                   s_ready;
    stream_pkg::beat_t      m_beat;
    logic                   m_ready;
    stream_pkg::rx_status_t status;

    integer seed       = seed_init;
    integer ready_seed = seed_init;
    logic   stall_on   = 1'b0;
    logic   sof_armed;
    int     cycles;

    logic [17:0]            exp_beats[$];
    stream_pkg::rx_status_t exp_status[$];

    csi2_rx_top #(
        .FIFO_DEPTH (fifo_depth)
    ) DUT (
        .s_axi4s   (s_axi4s),
        .rst       (rst),
        .data_type (data_type),
        .s_beat    (s_beat),
        .s_ready   (s_ready),
        .m_beat    (m_beat),
        .m_ready   (m_ready),
        .status    (status)
    );

    initial begin
        s_axi4s = 1'b0;
        forever #5 s_axi4s = ~s_axi4s;
    end

    // ------------------------------
    // reference model
    // ------------------------------
    // crc-16 byte by byte from the low byte
    function automatic logic [15:0] crc_fold(input logic [15:0] crc, input logic [15:0] word);
        logic [15:0] c;
        c = crc;
        for (int n = 0; n < 2; n++) begin
            c[7:0] = c[7:0] ^ word[8*n +: 8];
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
            end
        end
        return c;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic send_beat(input logic user, input logic last, input logic [15:0] data);
        s_beat.valid = 1'b1;
        s_beat.user  = user;
        s_beat.last  = last;
        s_beat.data  = data;
        do begin
            @(posedge s_axi4s);
        end while (!s_ready);
        @(negedge s_axi4s);
        s_beat = '0;
    endtask

    task automatic send_short(input logic [7:0] id, input logic [15:0] frame);
        csi2_pkg::ph_t          ph;
        logic [23:0]            hdr;
        logic [5:0]             ecc;
        stream_pkg::rx_status_t e;
        ph                    = '0;
        ph.data_id            = id;
        ph.field.frame_number = frame;
        hdr = {ph.field, ph.data_id};
        ecc = csi2_pkg::ecc_syndrome(hdr);
        e = '0;
        e.ecc_valid = 1'b1;
        exp_status.push_back(e);
        e = '0;
        e.frame_start = id == csi2_pkg::dt_frame_start;
        e.frame_end   = id == csi2_pkg::dt_frame_end;
        exp_status.push_back(e);
        if (id == csi2_pkg::dt_frame_start) begin
            sof_armed = 1'b1;
        end
        send_beat(1'b1, 1'b0, hdr[15:0]);
        send_beat(1'b0, 1'b1, {2'b00, ecc, hdr[23:16]});
    endtask

    // cut > 0 ends the transmission after that many payload words
    task automatic send_long(input logic [7:0] id, input int wc, input logic [23:0] flip,
                             input logic bad_crc, input int cut);
        logic [23:0]            hdr;
        logic [23:0]            tx;
        logic [5:0]             ecc;
        logic [15:0]            crc;
        logic [15:0]            word;
        logic                   dropped;
        logic                   deliver;
        logic                   tail;
        int                     words;
        stream_pkg::rx_status_t e;
        hdr     = {wc[15:0], id};
        ecc     = csi2_pkg::ecc_syndrome(hdr);
        tx      = hdr ^ flip;
        dropped = $countones(flip) > 1;
        deliver = !dropped && (id == data_type);
        words   = wc / 2;
        e = '0;
        e.ecc_valid     = 1'b1;
        e.ecc_corrected = $countones(flip) == 1;
        e.ecc_error     = dropped;
        exp_status.push_back(e);
        send_beat(1'b1, 1'b0, tx[15:0]);
        send_beat(1'b0, 1'b0, {2'b00, ecc, tx[23:16]});
        crc = 16'hffff;
        for (int k = 0; k < words && (cut == 0 || k < cut); k++) begin
            word = $random(seed);
            tail = k == cut - 1;
            crc  = crc_fold(crc, word);
            if (deliver) begin
                exp_beats.push_back({sof_armed, tail || (k == words - 1), word});
                sof_armed = 1'b0;
            end
            if (tail && !dropped) begin
                e = '0;
                e.packet_lost = 1'b1;
                exp_status.push_back(e);
            end
            send_beat(1'b0, tail, word);
        end
        if (cut == 0) begin
            if (deliver) begin
                e = '0;
                e.crc_valid = 1'b1;
                e.crc_error = bad_crc;
                exp_status.push_back(e);
            end
            send_beat(1'b0, 1'b1, crc ^ {15'd0, bad_crc});
        end
    endtask

    // ------------------------------
    // monitor and stall driver
    // ------------------------------
    always @(posedge s_axi4s) begin
        logic [17:0]            want;
        stream_pkg::rx_status_t want_status;
        if (!rst) begin
            if (m_beat.valid && m_ready) begin
                if (exp_beats.size() == 0) begin
                    abort_run("an output beat arrived when no beat was expected");
                end else begin
                    want = exp_beats.pop_front();
                    check_value("m_beat", {14'd0, m_beat.user, m_beat.last, m_beat.data},
                                {14'd0, want});
                end
            end
            if (status != '0) begin
                if (exp_status.size() == 0) begin
                    abort_run("a status strobe fired when no event was expected");
                end else begin
                    want_status = exp_status.pop_front();
                    check_value("status", {24'd0, status}, {24'd0, want_status});
                end
            end
        end
    end

    always @(negedge s_axi4s) begin
        if (stall_on) begin
            m_ready = ($random(ready_seed) & 3) != 0;
        end else begin
            m_ready = 1'b1;
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge s_axi4s);
            cycles++;
            if (cycles > cycle_limit) begin
                abort_run("timeout: the expected output did not drain within the cycle limit");
            end
        end
    end

    initial begin
        rst         = 1'b1;
        s_beat      = '0;
        m_ready     = 1'b1;
        data_type   = rx_type;
        sof_armed   = 1'b0;
        repeat (5) @(posedge s_axi4s);
        @(negedge s_axi4s);
        rst = 1'b0;

        // frame with one good packet
        send_short(csi2_pkg::dt_frame_start, 16'd1);
        send_long(rx_type, 16, 24'd0, 1'b0, 0);
        send_short(csi2_pkg::dt_frame_end, 16'd1);
        // other data type is parsed but not forwarded
        send_long(other_type, 12, 24'd0, 1'b0, 0);
        // one and two header bit errors
        send_short(csi2_pkg::dt_frame_start, 16'd2);
        send_long(rx_type, 8, 24'h000008, 1'b0, 0);
        send_long(rx_type, 8, 24'h000003, 1'b0, 0);
        send_short(csi2_pkg::dt_frame_end, 16'd2);
        send_long(rx_type, 10, 24'd0, 1'b1, 0);
        // early end followed by a clean packet
        send_long(rx_type, 20, 24'd0, 1'b0, 3);
        send_long(rx_type, 6, 24'd0, 1'b0, 0);

        stall_on = 1'b1;
        send_short(csi2_pkg::dt_frame_start, 16'd3);
        for (int i = 0; i < rand_packets; i++) begin
            send_long((i % 3 == 2) ? other_type : rx_type, rand_wc, 24'd0, 1'b0, 0);
        end
        send_short(csi2_pkg::dt_frame_end, 16'd3);

        while (exp_beats.size() != 0 || exp_status.size() != 0) begin
            @(posedge s_axi4s);
        end
        stall_on = 1'b0;
        // catch stray beats or strobes
        repeat (20) @(posedge s_axi4s);
        if (DUT.u_checker.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "simulation stopped");
        end
    end

endmodule

`default_nettype wire

//--- verilog/csi2_rx_top.sv
`default_nettype none

module csi2_rx_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  var logic                   s_axi4s,
    input  var logic                   rst,
    input  var logic [7:0]             data_type,
    input  var stream_pkg::beat_t      s_beat,
    output logic                       s_ready,
    output stream_pkg::beat_t          m_beat,
    input  var logic                   m_ready,
    output stream_pkg::rx_status_t     status
);

    stream_pkg::beat_t pkt_beat;
    logic              pkt_ready;

    csi2_rx_packet u_packet (
        .s_axi4s   (s_axi4s),
        .rst       (rst),
        .data_type (data_type),
        .s_beat    (s_beat),
        .s_ready   (s_ready),
        .m_beat    (pkt_beat),
        .m_ready   (pkt_ready),
        .status    (status)
    );

    // output buffer absorbs downstream stalls
    stream_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .s_axi4s (s_axi4s),
        .rst     (rst),
        .s_beat  (pkt_beat),
        .s_ready (pkt_ready),
        .m_beat  (m_beat),
        .m_ready (m_ready)
    );

endmodule

`default_nettype wire

//--- verilog/stream_fifo.sv
`default_nettype none

module stream_fifo #(
    parameter int DEPTH = 16
) (
    input  var logic              s_axi4s,
    input  var logic              rst,
    input  var stream_pkg::beat_t s_beat,
    output logic                  s_ready,
    output stream_pkg::beat_t     m_beat,
    input  var logic              m_ready
);

    localparam int addr_bits  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int count_bits = $clog2(DEPTH + 1);

    // user, last, data
    logic [17:0]           mem [DEPTH];
    logic [addr_bits-1:0]  wr_ptr;
    logic [addr_bits-1:0]  rd_ptr;
    logic [count_bits-1:0] count;
    logic                  wr_en;
    logic                  rd_en;

    assign s_ready = count != count_bits'(DEPTH);
    assign wr_en   = s_beat.valid && s_ready;
    assign rd_en   = (count != '0) && (!m_beat.valid || m_ready);

    always_ff @(posedge s_axi4s) begin
        if (wr_en) begin
            mem[wr_ptr] <= {s_beat.user, s_beat.last, s_beat.data};
        end
    end

    always_ff @(posedge s_axi4s) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            m_beat.valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == addr_bits'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            // output register refills only when empty or consumed
            if (rd_en) begin
                rd_ptr       <= (rd_ptr == addr_bits'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                m_beat.valid <= 1'b1;
                {m_beat.user, m_beat.last, m_beat.data} <= mem[rd_ptr];
            end else if (m_ready) begin
                m_beat.valid <= 1'b0;
            end
            count <= count + count_bits'(wr_en) - count_bits'(rd_en);
        end
    end

endmodule

`default_nettype wire
